/* source/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

  // ##############################
  // Widths
  // ##############################

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [3:0]  ecause_t;

  // ##############################
  // Exception causes
  // ##############################

  localparam ecause_t cause_misaligned_fetch = 4'd0;
  localparam ecause_t cause_illegal          = 4'd2;
  localparam ecause_t cause_breakpoint       = 4'd3;
  localparam ecause_t cause_ecall_m          = 4'd11;

  // ##############################
  // Major opcodes
  // ##############################

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_system = 7'b1110011;

  // ALU operations. pass_b serves LUI and the link value.
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    bcu_none,
    bcu_beq,
    bcu_bne,
    bcu_blt,
    bcu_bge,
    bcu_bltu,
    bcu_bgeu
  } bcu_op_e;

endpackage

`default_nettype wire

/* source/dec_exe_if.sv */
`default_nettype none
`timescale 1ns/1ns

interface dec_exe_if;
  import rv_pipe_pkg::*;

  logic      valid;
  xlen_t     pc;
  reg_addr_t rd;
  logic      wren;
  alu_op_e   alu_op;
  xlen_t     operand_a;
  xlen_t     operand_b;
  logic      jump;
  xlen_t     target;
  logic      exception;
  ecause_t   ecause;

  modport dec (
    output valid, pc, rd, wren, alu_op, operand_a, operand_b,
    output jump, target, exception, ecause
  );

  modport exe (
    input valid, pc, rd, wren, alu_op, operand_a, operand_b,
    input jump, target, exception, ecause
  );

endinterface

`default_nettype wire

/* source/instr_buffer.sv */
`default_nettype none
`timescale 1ns/1ns

module instr_buffer #(
  parameter int BUF_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                instr_valid,
  input  rv_pipe_pkg::xlen_t  instr_pc,
  input  rv_pipe_pkg::instr_t instr_word,
  input  logic                pop,
  output logic                instr_credit,
  output logic                empty,
  output rv_pipe_pkg::xlen_t  head_pc,
  output rv_pipe_pkg::instr_t head_word
);
  import rv_pipe_pkg::*;

  localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  xlen_t  pc_mem   [BUF_DEPTH];
  instr_t word_mem [BUF_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      pc_mem[wr_ptr]   <= instr_pc;
      word_mem[wr_ptr] <= instr_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      instr_credit <= 1'b0;
    end else begin
      if (instr_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({instr_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back to the agent per popped entry.
      instr_credit <= pop;
    end
  end

  assign empty     = (count == '0);
  assign head_pc   = pc_mem[rd_ptr];
  assign head_word = word_mem[rd_ptr];

endmodule

`default_nettype wire

/* source/register_file.sv */
`default_nettype none
`timescale 1ns/1ns

module register_file (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_pipe_pkg::reg_addr_t raddr1,
  input  rv_pipe_pkg::reg_addr_t raddr2,
  output rv_pipe_pkg::xlen_t     rdata1,
  output rv_pipe_pkg::xlen_t     rdata2,
  input  logic                   wr_en,
  input  rv_pipe_pkg::reg_addr_t wr_addr,
  input  rv_pipe_pkg::xlen_t     wr_data
);
  import rv_pipe_pkg::*;

  // x0 has no storage.
  xlen_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // No write bypass here; decode forwards from execute instead.
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`default_nettype none
`timescale 1ns/1ns

module decode_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   empty,
  input  rv_pipe_pkg::xlen_t     head_pc,
  input  rv_pipe_pkg::instr_t    head_word,
  input  rv_pipe_pkg::xlen_t     rdata1,
  input  rv_pipe_pkg::xlen_t     rdata2,
  input  logic                   fwd_valid,
  input  rv_pipe_pkg::reg_addr_t fwd_rd,
  input  rv_pipe_pkg::xlen_t     fwd_data,
  input  logic                   advance,
  output logic                   pop,
  output rv_pipe_pkg::reg_addr_t raddr1,
  output rv_pipe_pkg::reg_addr_t raddr2,
  dec_exe_if.dec                 de
);
  import rv_pipe_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd, rs1, rs2;
  xlen_t      imm_i, imm_u, imm_j, imm_b;
  xlen_t      src1, src2;
  xlen_t      op_a, op_b, target;
  alu_op_e    alu_op;
  bcu_op_e    bcu_op;
  logic       illegal, is_ecall, is_ebreak;
  logic       wren, jump, exception;
  ecause_t    ecause;

  // alt picks sub or sra.
  function automatic alu_op_e alu_from_funct3(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  // ##############################
  // Fields and operands
  // ##############################

  assign opcode = head_word[6:0];
  assign rd     = head_word[11:7];
  assign funct3 = head_word[14:12];
  assign rs1    = head_word[19:15];
  assign rs2    = head_word[24:20];
  assign funct7 = head_word[31:25];

  assign imm_i = {{20{head_word[31]}}, head_word[31:20]};
  assign imm_u = {head_word[31:12], 12'b0};
  assign imm_j = {{12{head_word[31]}}, head_word[19:12], head_word[20],
                  head_word[30:21], 1'b0};
  assign imm_b = {{20{head_word[31]}}, head_word[7], head_word[30:25],
                  head_word[11:8], 1'b0};

  assign raddr1 = rs1;
  assign raddr2 = rs2;

  assign src1 = (fwd_valid && (fwd_rd == rs1) && (rs1 != '0)) ? fwd_data : rdata1;
  assign src2 = (fwd_valid && (fwd_rd == rs2) && (rs2 != '0)) ? fwd_data : rdata2;

  // ##############################
  // Decode
  // ##############################

  always_comb begin
    illegal   = 1'b0;
    is_ecall  = 1'b0;
    is_ebreak = 1'b0;
    wren      = 1'b0;
    jump      = 1'b0;
    alu_op    = alu_add;
    bcu_op    = bcu_none;
    op_a      = src1;
    op_b      = src2;
    target    = '0;

    case (opcode)
      opc_op: begin
        wren    = 1'b1;
        alu_op  = alu_from_funct3(funct3, funct7[5]);
        illegal = !((funct7 == 7'b0000000) ||
                    ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101))));
      end
      opc_op_imm: begin
        wren   = 1'b1;
        op_b   = imm_i;
        alu_op = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      opc_lui: begin
        wren   = 1'b1;
        alu_op = alu_pass_b;
        op_b   = imm_u;
      end
      opc_auipc: begin
        wren = 1'b1;
        op_a = head_pc;
        op_b = imm_u;
      end
      opc_jal: begin
        wren   = 1'b1;
        jump   = 1'b1;
        alu_op = alu_pass_b;
        op_b   = head_pc + 32'd4;
        target = head_pc + imm_j;
      end
      opc_jalr: begin
        wren    = 1'b1;
        jump    = 1'b1;
        alu_op  = alu_pass_b;
        op_b    = head_pc + 32'd4;
        target  = (src1 + imm_i) & ~32'd1;
        illegal = (funct3 != 3'b000);
      end
      opc_branch: begin
        target = head_pc + imm_b;
        case (funct3)
          3'b000:  bcu_op = bcu_beq;
          3'b001:  bcu_op = bcu_bne;
          3'b100:  bcu_op = bcu_blt;
          3'b101:  bcu_op = bcu_bge;
          3'b110:  bcu_op = bcu_bltu;
          3'b111:  bcu_op = bcu_bgeu;
          default: illegal = 1'b1;
        endcase
      end
      opc_system: begin
        is_ecall  = (head_word == 32'h00000073);
        is_ebreak = (head_word == 32'h00100073);
        illegal   = !(is_ecall || is_ebreak);
      end
      default: illegal = 1'b1;
    endcase

    case (bcu_op)
      bcu_beq:  jump = (src1 == src2);
      bcu_bne:  jump = (src1 != src2);
      bcu_blt:  jump = ($signed(src1) < $signed(src2));
      bcu_bge:  jump = ($signed(src1) >= $signed(src2));
      bcu_bltu: jump = (src1 < src2);
      bcu_bgeu: jump = (src1 >= src2);
      default:  jump = jump;
    endcase

    exception = 1'b1;
    if (illegal) begin
      ecause = cause_illegal;
    end else if (is_ebreak) begin
      ecause = cause_breakpoint;
    end else if (is_ecall) begin
      ecause = cause_ecall_m;
    end else if (jump && target[1]) begin
      ecause = cause_misaligned_fetch;
    end else begin
      exception = 1'b0;
      ecause    = '0;
    end

    if (exception) begin
      wren = 1'b0;
      jump = 1'b0;
    end
  end

  assign pop = advance && !empty;

  // ##############################
  // Output register
  // ##############################

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      de.valid <= 1'b0;
    end else if (advance) begin
      de.valid <= !empty;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      de.pc        <= head_pc;
      de.rd        <= rd;
      de.wren      <= wren;
      de.alu_op    <= alu_op;
      de.operand_a <= op_a;
      de.operand_b <= op_b;
      de.jump      <= jump;
      de.target    <= target;
      de.exception <= exception;
      de.ecause    <= ecause;
    end
  end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`default_nettype none
`timescale 1ns/1ns

module execute_stage #(
  parameter int RETIRE_CREDITS = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  dec_exe_if.exe                 de,
  input  logic                   retire_credit,
  output logic                   advance,
  output logic                   fwd_valid,
  output rv_pipe_pkg::reg_addr_t fwd_rd,
  output rv_pipe_pkg::xlen_t     fwd_data,
  output logic                   wr_en,
  output rv_pipe_pkg::reg_addr_t wr_addr,
  output rv_pipe_pkg::xlen_t     wr_data,
  output logic                   retire_valid,
  output rv_pipe_pkg::xlen_t     retire_pc,
  output rv_pipe_pkg::reg_addr_t retire_rd,
  output logic                   retire_wren,
  output rv_pipe_pkg::xlen_t     retire_wdata,
  output logic                   retire_jump,
  output rv_pipe_pkg::xlen_t     retire_target,
  output logic                   retire_exception,
  output rv_pipe_pkg::ecause_t   retire_ecause
);
  import rv_pipe_pkg::*;

  localparam int CRED_W = $clog2(RETIRE_CREDITS + 1);

  xlen_t            result;
  logic [CRED_W-1:0] credits;
  logic             has_credit;
  logic             r_valid;

  // ##############################
  // ALU
  // ##############################

  always_comb begin
    case (de.alu_op)
      alu_add:  result = de.operand_a + de.operand_b;
      alu_sub:  result = de.operand_a - de.operand_b;
      alu_sll:  result = de.operand_a << de.operand_b[4:0];
      alu_slt:  result = {31'b0, $signed(de.operand_a) < $signed(de.operand_b)};
      alu_sltu: result = {31'b0, de.operand_a < de.operand_b};
      alu_xor:  result = de.operand_a ^ de.operand_b;
      alu_srl:  result = de.operand_a >> de.operand_b[4:0];
      alu_sra:  result = xlen_t'($signed(de.operand_a) >>> de.operand_b[4:0]);
      alu_or:   result = de.operand_a | de.operand_b;
      alu_and:  result = de.operand_a & de.operand_b;
      default:  result = de.operand_b;
    endcase
  end

  assign fwd_valid = de.valid && de.wren;
  assign fwd_rd    = de.rd;
  assign fwd_data  = result;

  // Results reach the register file as the instruction enters the retire
  // register, so decode never needs anything older than execute.
  assign wr_en   = de.valid && de.wren && advance;
  assign wr_addr = de.rd;
  assign wr_data = result;

  // ##############################
  // Retire and credits
  // ##############################

  assign has_credit   = (credits != '0);
  assign advance      = !r_valid || has_credit;
  assign retire_valid = r_valid && has_credit;

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      r_valid <= 1'b0;
      credits <= CRED_W'(RETIRE_CREDITS);
    end else begin
      if (advance) begin
        r_valid <= de.valid;
      end
      case ({retire_credit, retire_valid})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      retire_pc        <= de.pc;
      retire_rd        <= de.rd;
      retire_wren      <= de.wren;
      retire_wdata     <= result;
      retire_jump      <= de.jump;
      retire_target    <= de.target;
      retire_exception <= de.exception;
      retire_ecause    <= de.ecause;
    end
  end

endmodule

`default_nettype wire

/* source/rv_pipe_top.sv */
`default_nettype none
`timescale 1ns/1ns

module rv_pipe_top #(
  parameter int BUF_DEPTH      = 4,
  parameter int RETIRE_CREDITS = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instr_valid,
  input  rv_pipe_pkg::xlen_t     instr_pc,
  input  rv_pipe_pkg::instr_t    instr_word,
  output logic                   instr_credit,
  input  logic                   retire_credit,
  output logic                   retire_valid,
  output rv_pipe_pkg::xlen_t     retire_pc,
  output rv_pipe_pkg::reg_addr_t retire_rd,
  output logic                   retire_wren,
  output rv_pipe_pkg::xlen_t     retire_wdata,
  output logic                   retire_jump,
  output rv_pipe_pkg::xlen_t     retire_target,
  output logic                   retire_exception,
  output rv_pipe_pkg::ecause_t   retire_ecause
);
  import rv_pipe_pkg::*;

  logic      pop;
  logic      empty;
  xlen_t     head_pc;
  instr_t    head_word;
  reg_addr_t raddr1, raddr2;
  xlen_t     rdata1, rdata2;
  logic      fwd_valid;
  reg_addr_t fwd_rd;
  xlen_t     fwd_data;
  logic      advance;
  logic      wr_en;
  reg_addr_t wr_addr;
  xlen_t     wr_data;

  dec_exe_if de_if ();

  instr_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_buffer (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr_pc     (instr_pc),
    .instr_word   (instr_word),
    .pop          (pop),
    .instr_credit (instr_credit),
    .empty        (empty),
    .head_pc      (head_pc),
    .head_word    (head_word)
  );

  decode_stage u_decode (
    .clk       (clk),
    .rst       (rst),
    .empty     (empty),
    .head_pc   (head_pc),
    .head_word (head_word),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .fwd_valid (fwd_valid),
    .fwd_rd    (fwd_rd),
    .fwd_data  (fwd_data),
    .advance   (advance),
    .pop       (pop),
    .raddr1    (raddr1),
    .raddr2    (raddr2),
    .de        (de_if.dec)
  );

  register_file u_regs (
    .clk     (clk),
    .rst     (rst),
    .raddr1  (raddr1),
    .raddr2  (raddr2),
    .rdata1  (rdata1),
    .rdata2  (rdata2),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  execute_stage #(
    .RETIRE_CREDITS (RETIRE_CREDITS)
  ) u_execute (
    .clk              (clk),
    .rst              (rst),
    .de               (de_if.exe),
    .retire_credit    (retire_credit),
    .advance          (advance),
    .fwd_valid        (fwd_valid),
    .fwd_rd           (fwd_rd),
    .fwd_data         (fwd_data),
    .wr_en            (wr_en),
    .wr_addr          (wr_addr),
    .wr_data          (wr_data),
    .retire_valid     (retire_valid),
    .retire_pc        (retire_pc),
    .retire_rd        (retire_rd),
    .retire_wren      (retire_wren),
    .retire_wdata     (retire_wdata),
    .retire_jump      (retire_jump),
    .retire_target    (retire_target),
    .retire_exception (retire_exception),
    .retire_ecause    (retire_ecause)
  );

endmodule

`default_nettype wire

/* sim/rv_pipe_chk.sv */
`default_nettype none
`timescale 1ns/1ns

module rv_pipe_chk #(
  parameter int BUF_DEPTH      = 4,
  parameter int RETIRE_CREDITS = 2
) (
  input logic                                clk,
  input logic                                rst,
  input logic                                instr_credit,
  input logic                                retire_valid,
  input logic                                retire_credit,
  input rv_pipe_pkg::reg_addr_t              raddr1,
  input rv_pipe_pkg::reg_addr_t              raddr2,
  input rv_pipe_pkg::xlen_t                  src1,
  input rv_pipe_pkg::xlen_t                  src2,
  input logic [$clog2(BUF_DEPTH+1)-1:0]      buf_count,
  input logic [$clog2(RETIRE_CREDITS+1)-1:0] credits
);

  int held_credits;

  // Credits held by the core as seen from the retire port alone.
  always_ff @(posedge clk) begin
    if (rst == 0) begin
      held_credits <= RETIRE_CREDITS;
    end else begin
      held_credits <= held_credits + int'(retire_credit) - int'(retire_valid);
    end
  end

  a_retire_needs_credit: assert property (
    @(posedge clk) disable iff (rst == 1'b0) retire_valid |-> (held_credits > 0)
  ) else $error("Retire issued with no retire credit left.");

  a_credit_bound: assert property (
    @(posedge clk) disable iff (rst == 1'b0) credits <= RETIRE_CREDITS
  ) else $error("Retire credit count above its initial value.");

  a_buffer_bound: assert property (
    @(posedge clk) disable iff (rst == 1'b0) buf_count <= BUF_DEPTH
  ) else $error("Instruction buffer overfilled.");

  // An x0 source sees zero even while execute holds a write to x0.
  a_x0_port1: assert property (
    @(posedge clk) disable iff (rst == 1'b0) (raddr1 == '0) |-> (src1 == '0)
  ) else $error("Operand from x0 nonzero on port 1.");

  a_x0_port2: assert property (
    @(posedge clk) disable iff (rst == 1'b0) (raddr2 == '0) |-> (src2 == '0)
  ) else $error("Operand from x0 nonzero on port 2.");

  a_quiet_after_reset: assert property (
    @(posedge clk) (rst == 1'b0) |=> (!instr_credit && !retire_valid)
  ) else $error("Credit or retire output active after reset.");

endmodule

bind rv_pipe_top rv_pipe_chk #(
  .BUF_DEPTH      (BUF_DEPTH),
  .RETIRE_CREDITS (RETIRE_CREDITS)
) u_chk (
  .clk           (clk),
  .rst           (rst),
  .instr_credit  (instr_credit),
  .retire_valid  (retire_valid),
  .retire_credit (retire_credit),
  .raddr1        (raddr1),
  .raddr2        (raddr2),
  .src1          (u_decode.src1),
  .src2          (u_decode.src2),
  .buf_count     (u_buffer.count),
  .credits       (u_execute.credits)
);

`default_nettype wire

/* sim/rv_pipe_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module rv_pipe_tb;
  import rv_pipe_pkg::*;

  localparam int BUF_DEPTH       = 4;
  localparam int RETIRE_CREDITS  = 2;
  localparam int NUM_INSTR       = 400;
  localparam int RESET_CYCLES    = 16;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_INSTR * 40;

  typedef struct {
    xlen_t     pc;
    reg_addr_t rd;
    logic      wren;
    xlen_t     wdata;
    logic      jump;
    xlen_t     target;
    logic      exception;
    ecause_t   ecause;
  } exp_rec_t;

  logic      clk;
  logic      rst;
  logic      instr_valid;
  xlen_t     instr_pc;
  instr_t    instr_word;
  logic      instr_credit;
  logic      retire_credit;
  logic      retire_valid;
  xlen_t     retire_pc;
  reg_addr_t retire_rd;
  logic      retire_wren;
  xlen_t     retire_wdata;
  logic      retire_jump;
  xlen_t     retire_target;
  logic      retire_exception;
  ecause_t   retire_ecause;

  integer   seed;
  logic     running;
  int       sent;
  int       credit_pulses;
  int       retired;
  int       owed;
  xlen_t    next_pc;
  instr_t   gen_word;
  exp_rec_t want;
  exp_rec_t exp_q [$];
  xlen_t    model_regs [32];

  rv_pipe_top #(
    .BUF_DEPTH      (BUF_DEPTH),
    .RETIRE_CREDITS (RETIRE_CREDITS)
  ) DUT (
    .clk              (clk),
    .rst              (rst),
    .instr_valid      (instr_valid),
    .instr_pc         (instr_pc),
    .instr_word       (instr_word),
    .instr_credit     (instr_credit),
    .retire_credit    (retire_credit),
    .retire_valid     (retire_valid),
    .retire_pc        (retire_pc),
    .retire_rd        (retire_rd),
    .retire_wren      (retire_wren),
    .retire_wdata     (retire_wdata),
    .retire_jump      (retire_jump),
    .retire_target    (retire_target),
    .retire_exception (retire_exception),
    .retire_ecause    (retire_ecause)
  );

  always #5 clk = ~clk;

  // ##############################
  // Reporting and checks
  // ##############################

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t expv);
    if (got !== expv) begin
      report_failure($sformatf("Mismatch %s: got %h, expected %h", name, got, expv));
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t expv);
    if (got !== expv) begin
      report_failure($sformatf("Mismatch %s: got %h, expected %h", name, got, expv));
    end
  endtask

  task automatic check_cause(input string name, input ecause_t got, input ecause_t expv);
    if (got !== expv) begin
      report_failure($sformatf("Mismatch %s: got %h, expected %h", name, got, expv));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expv);
    if (got !== expv) begin
      report_failure($sformatf("Mismatch %s: got %h, expected %h", name, got, expv));
    end
  endtask

  // ##############################
  // Reference model
  // ##############################

  function automatic xlen_t int_alu(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic exp_rec_t ref_exec(xlen_t pc, instr_t w);
    exp_rec_t   r;
    logic [2:0] f3;
    logic [6:0] f7;
    xlen_t      a;
    xlen_t      b;
    xlen_t      imm;
    logic       illegal;
    logic       ecall;
    logic       ebreak;
    f3      = w[14:12];
    f7      = w[31:25];
    a       = model_regs[w[19:15]];
    b       = model_regs[w[24:20]];
    imm     = {{20{w[31]}}, w[31:20]};
    illegal = 1'b0;
    ecall   = 1'b0;
    ebreak  = 1'b0;
    r.pc        = pc;
    r.rd        = w[11:7];
    r.wren      = 1'b0;
    r.wdata     = '0;
    r.jump      = 1'b0;
    r.target    = '0;
    r.exception = 1'b0;
    r.ecause    = '0;
    case (w[6:0])
      opc_op: begin
        r.wren  = 1'b1;
        illegal = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
        r.wdata = int_alu(f3, f7[5], a, b);
      end
      opc_op_imm: begin
        r.wren = 1'b1;
        if (f3 == 3'd1) begin
          illegal = (f7 != 7'h00);
        end else if (f3 == 3'd5) begin
          illegal = (f7 != 7'h00) && (f7 != 7'h20);
        end
        r.wdata = int_alu(f3, (f3 == 3'd5) && f7[5], a, imm);
      end
      opc_lui: begin
        r.wren  = 1'b1;
        r.wdata = {w[31:12], 12'b0};
      end
      opc_auipc: begin
        r.wren  = 1'b1;
        r.wdata = pc + {w[31:12], 12'b0};
      end
      opc_jal: begin
        r.wren   = 1'b1;
        r.wdata  = pc + 32'd4;
        r.jump   = 1'b1;
        r.target = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      opc_jalr: begin
        illegal  = (f3 != 3'd0);
        r.wren   = 1'b1;
        r.wdata  = pc + 32'd4;
        r.jump   = 1'b1;
        r.target = (a + imm) & 32'hffff_fffe;
      end
      opc_branch: begin
        r.target = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        case (f3)
          3'd0:    r.jump = (a == b);
          3'd1:    r.jump = (a != b);
          3'd4:    r.jump = ($signed(a) < $signed(b));
          3'd5:    r.jump = ($signed(a) >= $signed(b));
          3'd6:    r.jump = (a < b);
          3'd7:    r.jump = (a >= b);
          default: illegal = 1'b1;
        endcase
      end
      opc_system: begin
        ecall   = (w == 32'h0000_0073);
        ebreak  = (w == 32'h0010_0073);
        illegal = !(ecall || ebreak);
      end
      default: illegal = 1'b1;
    endcase
    // Priority follows the cause order of the core.
    r.exception = 1'b1;
    if (illegal) begin
      r.ecause = cause_illegal;
    end else if (ebreak) begin
      r.ecause = cause_breakpoint;
    end else if (ecall) begin
      r.ecause = cause_ecall_m;
    end else if (r.jump && r.target[1]) begin
      r.ecause = cause_misaligned_fetch;
    end else begin
      r.exception = 1'b0;
    end
    if (r.exception) begin
      r.wren = 1'b0;
      r.jump = 1'b0;
    end
    if (r.wren && (r.rd != '0)) begin
      model_regs[r.rd] = r.wdata;
    end
    return r;
  endfunction

  // ##############################
  // Stimulus
  // ##############################

  function automatic instr_t gen_instr();
    logic [31:0] r;
    logic [31:0] v;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [20:0] jimm;
    logic [12:0] bimm;
    r    = $random(seed);
    v    = $random(seed);
    // Few registers, so dependent pairs are common.
    rd   = {2'b00, r[10:8]};
    rs1  = {2'b00, r[13:11]};
    rs2  = {2'b00, r[16:14]};
    f3   = r[19:17];
    f7   = (r[20] && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'h00;
    jimm = {v[20:2], v[25] & v[26], 1'b0};
    bimm = {v[12:2], v[25] & v[26], 1'b0};
    case (r[3:0])
      4'd0, 4'd1, 4'd2: return {f7, rs2, rs1, f3, rd, opc_op};
      4'd3, 4'd4, 4'd5, 4'd15: begin
        if ((f3 == 3'd1) || (f3 == 3'd5)) begin
          return {(f3 == 3'd5) ? f7 : 7'h00, v[4:0], rs1, f3, rd, opc_op_imm};
        end
        return {v[11:0], rs1, f3, rd, opc_op_imm};
      end
      4'd6: return {v[31:12], rd, opc_lui};
      4'd7: return {v[31:12], rd, opc_auipc};
      4'd8: return {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd, opc_jal};
      4'd9: return {v[11:0], rs1, 3'd0, rd, opc_jalr};
      4'd10, 4'd11: begin
        if ((f3 == 3'd2) || (f3 == 3'd3)) begin
          f3 = f3 + 3'd4;
        end
        return {bimm[12], bimm[10:5], rs2, rs1, f3, bimm[4:1], bimm[11], opc_branch};
      end
      4'd12: return 32'h0000_0073;
      4'd13: return 32'h0010_0073;
      default: begin
        case (v[28:27])
          2'd0:    return {v[31:7], 7'h03};
          2'd1:    return {7'h01, rs2, rs1, f3, rd, opc_op};
          2'd2:    return {v[11:0], rs1, 3'd1, rd, opc_jalr};
          default: return 32'h3020_0073;
        endcase
      end
    endcase
  endfunction

  // Sends run without gaps in the first half.
  function automatic logic send_gap();
    logic [31:0] r;
    r = $random(seed);
    return (sent >= NUM_INSTR / 2) && (r[2:0] == 3'd0);
  endfunction

  function automatic logic return_now();
    logic [31:0] r;
    r = $random(seed);
    if (retired < 120) begin
      return 1'b1;
    end
    return ((retired / 50) % 2 == 1) ? (r[1:0] == 2'd0) : r[0];
  endfunction

  always @(posedge clk) begin
    if (running) begin
      if ((sent < NUM_INSTR) && (sent - credit_pulses < BUF_DEPTH) && !send_gap()) begin
        gen_word = gen_instr();
        exp_q.push_back(ref_exec(next_pc, gen_word));
        instr_valid <= 1'b1;
        instr_pc    <= next_pc;
        instr_word  <= gen_word;
        next_pc     = next_pc + 32'd4;
        sent        = sent + 1;
      end else begin
        instr_valid <= 1'b0;
      end
      if ((owed > 0) && return_now()) begin
        retire_credit <= 1'b1;
        owed          = owed - 1;
      end else begin
        retire_credit <= 1'b0;
      end
    end
  end

  // ##############################
  // Compare and watchdog
  // ##############################

  always @(negedge clk) begin
    if (rst == 1'b1) begin
      if (instr_credit) begin
        credit_pulses = credit_pulses + 1;
      end
      if (retire_valid) begin
        if (exp_q.size() == 0) begin
          report_failure("A record retired with no instruction outstanding.");
        end else begin
          want = exp_q.pop_front();
          check_word("retire_pc", retire_pc, want.pc);
          check_bit("retire_exception", retire_exception, want.exception);
          check_cause("retire_ecause", retire_ecause, want.ecause);
          check_bit("retire_wren", retire_wren, want.wren);
          check_bit("retire_jump", retire_jump, want.jump);
          if (want.wren) begin
            check_reg("retire_rd", retire_rd, want.rd);
            check_word("retire_wdata", retire_wdata, want.wdata);
          end
          if (want.jump) begin
            check_word("retire_target", retire_target, want.target);
          end
          retired = retired + 1;
          owed    = owed + 1;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_failure($sformatf("Timeout with %0d of %0d instructions retired.",
                             retired, NUM_INSTR));
  end

  initial begin
    seed          = 12;
    clk           = 1'b0;
    rst           = 1'b0;
    running       = 1'b0;
    instr_valid   = 1'b0;
    instr_pc      = '0;
    instr_word    = '0;
    retire_credit = 1'b0;
    sent          = 0;
    credit_pulses = 0;
    retired       = 0;
    owed          = 0;
    next_pc       = 32'h0000_1000;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst     <= 1'b1;
    running <= 1'b1;
    wait (retired == NUM_INSTR);
    // Idle a while so a stray extra retire would still show up.
    repeat (20) @(posedge clk);
    if ((credit_pulses == NUM_INSTR) && (retired == NUM_INSTR) && (exp_q.size() == 0)) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      report_failure($sformatf("Counts wrong: %0d credits and %0d retires for %0d sent.",
                               credit_pulses, retired, sent));
    end
  end

endmodule

`default_nettype wire

/* rv_pipe.f */
source/rv_pipe_pkg.sv
source/dec_exe_if.sv
source/instr_buffer.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/rv_pipe_top.sv
sim/rv_pipe_chk.sv
sim/rv_pipe_tb.sv

/* Bender.yml */
package:
  name: rv_pipe

sources:
  - source/rv_pipe_pkg.sv
  - source/dec_exe_if.sv
  - source/instr_buffer.sv
  - source/register_file.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/rv_pipe_top.sv
  - target: simulation
    files:
      - sim/rv_pipe_chk.sv
      - sim/rv_pipe_tb.sv
